//--- src/vlsu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, encodings and bus structs for the vector load/store unit
// Imported by every LSU block that needs a type or a helper function
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package vlsu_pkg;

    localparam int XLEN       = 32;              // Scalar register / address width
    localparam int VLEN       = 256;             // Vector register width
    localparam int BUS_W      = 32;              // Memory data bus
    localparam int STRB_W     = BUS_W / 8;       // One strobe bit per bus byte
    localparam int MAX_ELEMS  = VLEN / 8;        // Byte elements fill a register
    localparam int ELEM_IDX_W = $clog2(MAX_ELEMS);
    localparam int VL_W       = $clog2(MAX_ELEMS + 1);
    localparam int ELEM_OFS_W = ELEM_IDX_W + 6;  // Bit offset of an element in a register

    // Encoded as log2 of the element bytes
    typedef enum logic [1:0] {
        EW8  = 2'd0,
        EW16 = 2'd1,
        EW32 = 2'd2
    } elem_width_e;

    typedef enum logic [1:0] {
        AM_UNIT    = 2'd0,
        AM_STRIDED = 2'd1,
        AM_INDEXED = 2'd2
    } addr_mode_e;

    // Operands held for the whole instruction
    typedef struct packed {
        logic [XLEN-1:0] base;    // rs1
        logic [XLEN-1:0] stride;  // rs2, strided mode only
        addr_mode_e      mode;
        elem_width_e     width;
        logic [VL_W-1:0] vl;      // Element count, 1 to MAX_ELEMS
    } lsu_cmd_t;

    // One single-element memory request
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [BUS_W-1:0]  wdata;   // Element in low lanes
        logic [STRB_W-1:0] strobe;
        logic              ld_req;
        logic              st_req;
    } mem_req_t;

    // Bit position of element idx inside a vector register
    function automatic logic [ELEM_OFS_W-1:0] elem_bit_ofs(input logic [ELEM_IDX_W-1:0] idx,
                                                           input elem_width_e w);
        return {3'b000, idx, 3'b000} << w;
    endfunction

    // Low-bit mask covering one element
    function automatic logic [XLEN-1:0] elem_mask(input elem_width_e w);
        case (w)
            EW8:     return 32'h0000_00ff;
            EW16:    return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- src/vlsu_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store sequencing FSM
// Holds the request strobes for one instruction and pulses done at the end
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vlsu_ctrl (
    input  logic clk,
    input  logic n_rst,
    input  logic ld_inst,      // Start pulses, only seen in idle
    input  logic st_inst,
    input  logic last_elem,    // Current request is the final element
    output logic start,
    output logic step,
    output logic ld_req,
    output logic st_req,
    output logic rsp_capture,  // Load data on the bus this cycle
    output logic done
);

    typedef enum logic [1:0] {
        IDLE,
        LOADING,
        STORING
    } state_e;

    state_e state, state_next;

    // Load wins if both pulses arrive together
    assign start  = (state == IDLE) && (ld_inst || st_inst);
    assign ld_req = (state == LOADING);
    assign st_req = (state == STORING);
    assign step   = ld_req || st_req;  // One element per request cycle

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (ld_inst) begin
                    state_next = LOADING;
                end else if (st_inst) begin
                    state_next = STORING;
                end
            end
            LOADING,
            STORING: begin
                if (last_elem) state_next = IDLE;  // Final request issued
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state       <= IDLE;
            rsp_capture <= 1'b0;
            done        <= 1'b0;
        end else begin
            state       <= state_next;
            rsp_capture <= ld_req;  // Memory answers one cycle later
            // Last load response just captured, or last store just sent
            done        <= (rsp_capture && !ld_req) || (st_req && last_elem);
        end
    end

endmodule

`default_nettype wire

//--- src/vlsu_addr_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Element counter and per-element address register
// Covers unit-stride, constant-stride and index-ordered modes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vlsu_addr_gen #(
    parameter int VLEN = vlsu_pkg::VLEN
) (
    input  logic                            clk,
    input  logic                            n_rst,
    input  vlsu_pkg::lsu_cmd_t              cmd,
    input  logic [VLEN-1:0]                 vs2_data,   // Index vector
    input  logic                            start,      // Load base, clear counter
    input  logic                            step,       // Advance one element
    output logic [vlsu_pkg::XLEN-1:0]       addr,
    output logic [vlsu_pkg::ELEM_IDX_W-1:0] elem_idx,
    output logic                            last_elem
);

    import vlsu_pkg::*;

    logic [ELEM_IDX_W-1:0] idx_sel;     // Element whose address is loaded next
    logic [XLEN-1:0]       idx_off;     // Zero-extended index from vs2
    logic [XLEN-1:0]       elem_bytes;  // 1, 2 or 4
    logic [XLEN-1:0]       addr_next;

    // Index of the element the register will hold after this edge
    assign idx_sel = start ? '0 : elem_idx + 1'b1;

    // Shift keeps the select in range past the last element
    assign idx_off = XLEN'(vs2_data >> elem_bit_ofs(idx_sel, cmd.width)) & elem_mask(cmd.width);

    assign elem_bytes = XLEN'(1) << cmd.width;

    always_comb begin
        case (cmd.mode)
            AM_STRIDED: addr_next = addr + cmd.stride;    // Stride from rs2
            AM_INDEXED: addr_next = cmd.base + idx_off;   // Base plus vs2 offset
            default:    addr_next = addr + elem_bytes;    // Unit stride
        endcase
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            elem_idx <= '0;
            addr     <= '0;
        end else if (start) begin
            elem_idx <= '0;
            // Element 0 sits at base except in indexed mode
            addr     <= (cmd.mode == AM_INDEXED) ? cmd.base + idx_off : cmd.base;
        end else if (step) begin
            elem_idx <= elem_idx + 1'b1;
            addr     <= addr_next;
        end
    end

    // vl is never zero
    assign last_elem = (VL_W'(elem_idx) == cmd.vl - 1'b1);

endmodule

`default_nettype wire

//--- src/vlsu_load_gather.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load data path into the destination vector register
// Writes each returned element into its slot one cycle after its request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vlsu_load_gather #(
    parameter int VLEN  = vlsu_pkg::VLEN,
    parameter int BUS_W = vlsu_pkg::BUS_W
) (
    input  logic                            clk,
    input  logic                            n_rst,
    input  vlsu_pkg::elem_width_e           width,
    input  logic [vlsu_pkg::ELEM_IDX_W-1:0] elem_idx,     // Element being requested
    input  logic                            start,        // Load start only
    input  logic                            step,
    input  logic                            rsp_capture,
    input  logic [BUS_W-1:0]                mem_rdata,
    output logic [VLEN-1:0]                 vd_data
);

    import vlsu_pkg::*;

    logic [ELEM_IDX_W-1:0] rsp_idx;    // Slot of the response on the bus now
    logic [ELEM_OFS_W-1:0] slot_ofs;
    logic [VLEN-1:0]       slot_mask;
    logic [VLEN-1:0]       slot_data;

    // Request index follows its data by one cycle
    always_ff @(posedge clk) begin
        if (step) rsp_idx <= elem_idx;
    end

    assign slot_ofs  = elem_bit_ofs(rsp_idx, width);
    assign slot_mask = VLEN'(elem_mask(width)) << slot_ofs;
    // Element sits in the low bus lanes
    assign slot_data = VLEN'(mem_rdata[XLEN-1:0] & elem_mask(width)) << slot_ofs;

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vd_data <= '0;
        end else if (start) begin
            vd_data <= '0;  // Slots at and above vl read zero
        end else if (rsp_capture) begin
            vd_data <= (vd_data & ~slot_mask) | slot_data;
        end
    end

endmodule

`default_nettype wire

//--- src/vlsu_store_drive.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store data path
// Picks the current element from vs3 and builds write data and strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vlsu_store_drive #(
    parameter int VLEN  = vlsu_pkg::VLEN,
    parameter int BUS_W = vlsu_pkg::BUS_W
) (
    input  vlsu_pkg::elem_width_e           width,
    input  logic [vlsu_pkg::ELEM_IDX_W-1:0] elem_idx,
    input  logic [VLEN-1:0]                 vs3_data,   // Store vector
    output logic [BUS_W-1:0]                wdata,
    output logic [BUS_W/8-1:0]              strobe
);

    import vlsu_pkg::*;

    localparam int STRB_W = BUS_W / 8;

    logic [XLEN-1:0] elem;  // Selected element, zero above its width

    // Shift select stays defined for any counter value
    assign elem  = XLEN'(vs3_data >> elem_bit_ofs(elem_idx, width)) & elem_mask(width);
    assign wdata = BUS_W'(elem);  // Low lanes only

    always_comb begin
        case (width)
            EW8:     strobe = STRB_W'(4'b0001);
            EW16:    strobe = STRB_W'(4'b0011);
            EW32:    strobe = STRB_W'(4'b1111);
            default: strobe = '0;  // Unused encoding writes nothing
        endcase
    end

endmodule

`default_nettype wire

//--- src/vlsu_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector load/store unit top level
// One vector memory instruction in, one element request per cycle out
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vlsu_top #(
    parameter int VLEN  = vlsu_pkg::VLEN,
    parameter int BUS_W = vlsu_pkg::BUS_W
) (
    input  logic               clk,
    input  logic               n_rst,
    input  vlsu_pkg::lsu_cmd_t cmd,        // Stable until done
    input  logic               ld_inst,
    input  logic               st_inst,
    input  logic [VLEN-1:0]    vs2_data,   // Index vector
    input  logic [VLEN-1:0]    vs3_data,   // Store vector
    input  logic [BUS_W-1:0]   mem_rdata,  // Valid the cycle after ld_req
    output vlsu_pkg::mem_req_t mem_req,
    output logic [VLEN-1:0]    vd_data,
    output logic               done
);

    import vlsu_pkg::*;

    logic                  start, step, ld_start;
    logic                  ld_req, st_req;
    logic                  rsp_capture, last_elem;
    logic [XLEN-1:0]       addr;
    logic [ELEM_IDX_W-1:0] elem_idx;
    logic [BUS_W-1:0]      wdata;
    logic [BUS_W/8-1:0]    strobe;

    // Only a load clears the destination register
    assign ld_start = start && ld_inst;

    vlsu_ctrl ctrl_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .ld_inst     (ld_inst),
        .st_inst     (st_inst),
        .last_elem   (last_elem),
        .start       (start),
        .step        (step),
        .ld_req      (ld_req),
        .st_req      (st_req),
        .rsp_capture (rsp_capture),
        .done        (done)
    );

    vlsu_addr_gen #(.VLEN(VLEN)) addr_gen_inst (
        .clk       (clk),
        .n_rst     (n_rst),
        .cmd       (cmd),
        .vs2_data  (vs2_data),
        .start     (start),
        .step      (step),
        .addr      (addr),
        .elem_idx  (elem_idx),
        .last_elem (last_elem)
    );

    vlsu_load_gather #(.VLEN(VLEN), .BUS_W(BUS_W)) load_gather_inst (
        .clk         (clk),
        .n_rst       (n_rst),
        .width       (cmd.width),
        .elem_idx    (elem_idx),
        .start       (ld_start),
        .step        (step),
        .rsp_capture (rsp_capture),
        .mem_rdata   (mem_rdata),
        .vd_data     (vd_data)
    );

    vlsu_store_drive #(.VLEN(VLEN), .BUS_W(BUS_W)) store_drive_inst (
        .width    (cmd.width),
        .elem_idx (elem_idx),
        .vs3_data (vs3_data),
        .wdata    (wdata),
        .strobe   (strobe)
    );

    // Strobe low outside store requests
    assign mem_req = '{
        addr:   addr,
        wdata:  wdata,
        strobe: st_req ? strobe : '0,
        ld_req: ld_req,
        st_req: st_req
    };

endmodule

`default_nettype wire

//--- dv/vlsu_tb_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral byte memory for the LSU testbench
// Read data one cycle after ld_req, byte-strobed writes
// Fill port preloads one byte per clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vlsu_tb_mem #(
    parameter int DEPTH = 1024,               // Bytes, power of two
    parameter int BUS_W = vlsu_pkg::BUS_W
) (
    input  logic                     clk,
    input  vlsu_pkg::mem_req_t       req,
    input  logic                     fill_en,     // Preload write
    input  logic [$clog2(DEPTH)-1:0] fill_addr,
    input  logic [7:0]               fill_data,
    output logic [BUS_W-1:0]         rdata        // Valid the cycle after ld_req
);

    localparam int AW = $clog2(DEPTH);

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (fill_en) mem[fill_addr] <= fill_data;
        // Little endian, addresses wrap at the top of the array
        for (int b = 0; b < BUS_W / 8; b++) begin
            if (req.st_req && req.strobe[b]) begin
                mem[AW'(req.addr + 32'(b))] <= req.wdata[8*b +: 8];
            end
            if (req.ld_req) rdata[8*b +: 8] <= mem[AW'(req.addr + 32'(b))];
        end
    end

endmodule

`default_nettype wire

//--- dv/vlsu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the vector load/store unit
// Applies a table of load/store rows, predicts every request from a shadow memory
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/100ps
`default_nettype none

module vlsu_tb;

    import vlsu_pkg::*;

    localparam int DEPTH   = 1024;
    localparam int AW      = $clog2(DEPTH);
    localparam int TIMEOUT = 64;   // Cycles allowed per instruction
    localparam int NROWS   = 17;

    typedef struct packed {
        logic            is_st;
        addr_mode_e      mode;
        elem_width_e     width;
        logic [31:0]     base;
        logic [31:0]     stride;
        logic [VL_W-1:0] vl;
    } row_t;

    logic            clk, n_rst, ld_inst, st_inst, done;
    lsu_cmd_t        cmd;
    logic [VLEN-1:0] vs2_data, vs3_data, vd_data;
    logic [BUS_W-1:0] mem_rdata;
    mem_req_t        mem_req;
    logic            fill_en;
    logic [AW-1:0]   fill_addr;
    logic [7:0]      fill_data;
    logic [7:0]      shadow [DEPTH];  // Expected memory contents
    logic [31:0]     rng;
    int              value_errs, other_errs;

    row_t rows [NROWS] = '{
        '{1'b0, AM_UNIT,    EW8,  32'h0000_0040, 32'd0,         VL_W'(17)},  // Unit loads
        '{1'b0, AM_UNIT,    EW16, 32'h0000_0102, 32'd0,         VL_W'(16)},
        '{1'b0, AM_UNIT,    EW32, 32'h0000_0200, 32'd0,         VL_W'(8)},
        '{1'b0, AM_STRIDED, EW16, 32'h0000_0300, 32'd7,         VL_W'(9)},   // Odd stride
        '{1'b0, AM_STRIDED, EW32, 32'h0000_0080, 32'hffff_fffb, VL_W'(8)},   // Backwards
        '{1'b0, AM_INDEXED, EW8,  32'h0000_0380, 32'd0,         VL_W'(24)},
        '{1'b0, AM_INDEXED, EW32, 32'h0000_0010, 32'd0,         VL_W'(6)},
        '{1'b1, AM_UNIT,    EW8,  32'h0000_0140, 32'd0,         VL_W'(12)},  // Stores
        '{1'b1, AM_STRIDED, EW16, 32'h0000_01a1, 32'd3,         VL_W'(10)},
        '{1'b1, AM_INDEXED, EW32, 32'h0000_0240, 32'd0,         VL_W'(8)},
        '{1'b1, AM_UNIT,    EW32, 32'h0000_02f0, 32'd0,         VL_W'(5)},
        '{1'b1, AM_STRIDED, EW8,  32'h0000_0050, 32'd9,         VL_W'(20)},
        '{1'b1, AM_INDEXED, EW16, 32'h0000_03c0, 32'd0,         VL_W'(16)},  // Wraps memory
        '{1'b1, AM_UNIT,    EW8,  32'h0000_0000, 32'd0,         VL_W'(1)},   // Back to back
        '{1'b0, AM_UNIT,    EW8,  32'h0000_0000, 32'd0,         VL_W'(1)},
        '{1'b1, AM_UNIT,    EW8,  32'h0000_0180, 32'd0,         VL_W'(MAX_ELEMS)},
        '{1'b0, AM_UNIT,    EW8,  32'h0000_0180, 32'd0,         VL_W'(MAX_ELEMS)}
    };

    vlsu_top vlsu_top_inst (
        .clk(clk), .n_rst(n_rst), .cmd(cmd), .ld_inst(ld_inst), .st_inst(st_inst),
        .vs2_data(vs2_data), .vs3_data(vs3_data), .mem_rdata(mem_rdata),
        .mem_req(mem_req), .vd_data(vd_data), .done(done)
    );

    vlsu_tb_mem #(.DEPTH(DEPTH)) mem_inst (
        .clk(clk), .req(mem_req), .fill_en(fill_en), .fill_addr(fill_addr),
        .fill_data(fill_data), .rdata(mem_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic int width_bytes(input elem_width_e w);
        case (w)
            EW8:     return 1;
            EW16:    return 2;
            default: return 4;
        endcase
    endfunction

    // Element i of a register, zero above its width
    function automatic logic [31:0] vec_elem(input logic [VLEN-1:0] v, input int i, input int eb);
        logic [VLEN-1:0] s;
        s = v >> (i * eb * 8);
        return (eb == 4) ? s[31:0] : s[31:0] & ((32'd1 << (eb * 8)) - 32'd1);
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] a, input int eb);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < eb; b++) v[8*b +: 8] = shadow[AW'(a + 32'(b))];
        return v;
    endfunction

    function automatic logic [31:0] elem_addr(input row_t r, input int i);
        case (r.mode)
            AM_STRIDED: return r.base + r.stride * 32'(i);
            AM_INDEXED: return r.base + vec_elem(vs2_data, i, width_bytes(r.width));
            default:    return r.base + 32'(i * width_bytes(r.width));
        endcase
    endfunction

    task automatic check_value(input string name, input logic [VLEN-1:0] got,
                               input logic [VLEN-1:0] exp);
        assert (got === exp) else begin
            value_errs++;
            $display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // No request on the bus
    task automatic check_idle(input logic done_exp);
        check_value("mem_req.ld_req", mem_req.ld_req, '0);
        check_value("mem_req.st_req", mem_req.st_req, '0);
        check_value("mem_req.strobe", mem_req.strobe, '0);
        check_value("done", done, done_exp);
    endtask

    // Starts at a falling edge, returns at the falling edge of the done cycle
    task automatic run_row(input row_t r);
        int              eb;
        int              exp_done;
        logic [31:0]     a;
        logic [31:0]     d;
        logic [VLEN-1:0] exp_vd;
        bit              seen_done;
        eb        = width_bytes(r.width);
        exp_done  = int'(r.vl) + (r.is_st ? 1 : 2);
        seen_done = 1'b0;
        exp_vd    = '0;
        vs2_data  = '0;
        for (int i = 0; i < VLEN / (8 * eb); i++) begin
            rng = xorshift32(rng);
            vs2_data |= VLEN'(rng[7:0]) << (i * eb * 8);  // Small indices
        end
        for (int j = 0; j < VLEN / 32; j++) begin
            rng = xorshift32(rng);
            vs3_data[32*j +: 32] = rng;
        end
        cmd     = '{base: r.base, stride: r.stride, mode: r.mode, width: r.width, vl: r.vl};
        ld_inst = !r.is_st;
        st_inst = r.is_st;
        for (int cyc = 1; cyc <= TIMEOUT && !seen_done; cyc++) begin
            @(negedge clk);
            ld_inst = 1'b0;
            st_inst = 1'b0;
            if (cyc <= int'(r.vl)) begin
                a = elem_addr(r, cyc - 1);  // Element cyc-1 on the bus
                check_value("mem_req.addr", mem_req.addr, a);
                check_value("mem_req.ld_req", mem_req.ld_req, !r.is_st);
                check_value("mem_req.st_req", mem_req.st_req, r.is_st);
                check_value("done", done, '0);
                if (r.is_st) begin
                    d = vec_elem(vs3_data, cyc - 1, eb);
                    check_value("mem_req.wdata", mem_req.wdata, d);
                    check_value("mem_req.strobe", mem_req.strobe, (1 << eb) - 1);
                    for (int b = 0; b < eb; b++) shadow[AW'(a + 32'(b))] = d[8*b +: 8];
                end else begin
                    exp_vd |= VLEN'(shadow_read(a, eb)) << ((cyc - 1) * eb * 8);
                end
            end else begin
                check_idle(cyc == exp_done);
            end
            seen_done = done;
        end
        if (!seen_done) begin
            other_errs++;
            $display("Timeout at %0t ns: done never arrived within %0d cycles", $time, TIMEOUT);
        end else if (r.is_st) begin
            for (int k = 0; k < DEPTH; k++) begin
                check_value($sformatf("mem[%0h]", k), mem_inst.mem[k], shadow[k]);
            end
        end else begin
            check_value("vd_data", vd_data, exp_vd);
        end
    endtask

    initial begin
        value_errs = 0;
        other_errs = 0;
        n_rst      = 1'b0;
        ld_inst    = 1'b0;
        st_inst    = 1'b0;
        cmd        = '0;
        vs2_data   = '0;
        vs3_data   = '0;
        fill_en    = 1'b0;
        fill_addr  = '0;
        fill_data  = '0;
        rng        = 32'h32fd;
        repeat (16) begin
            @(negedge clk);
            check_idle(1'b0);
        end
        n_rst = 1'b1;
        // Preload while the LSU sits idle
        for (int a = 0; a < DEPTH; a++) begin
            rng       = xorshift32(rng);
            fill_en   = 1'b1;
            fill_addr = AW'(a);
            fill_data = rng[7:0];
            shadow[a] = rng[7:0];
            @(negedge clk);
            check_idle(1'b0);
        end
        fill_en = 1'b0;
        foreach (rows[i]) run_row(rows[i]);
        $display("Error counts: %0d mismatches, %0d timeouts", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
src/vlsu_pkg.sv
src/vlsu_ctrl.sv
src/vlsu_addr_gen.sv
src/vlsu_load_gather.sv
src/vlsu_store_drive.sv
src/vlsu_top.sv
dv/vlsu_tb_mem.sv
dv/vlsu_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := vlsu_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
